// File: src/eeprom_bus_pkg.sv
`default_nettype none

package eeprom_bus_pkg;

    // byte address into the 2 KB array
    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;

    // address bits that ride in the control byte
    localparam int BLOCK_W = ADDR_W - DATA_W;

    // 24Cxx device type code in the top nibble of the control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    // lsb of the control byte
    localparam logic RW_WRITE = 1'b0;
    localparam logic RW_READ  = 1'b1;

endpackage

`default_nettype wire

// File: src/eeprom_ctrl_pkg.sv
`default_nettype none

package eeprom_ctrl_pkg;

    // commands accepted by the bit engine
    typedef enum logic [2:0] {
        OP_START,
        OP_RESTART,
        OP_WRITE_BYTE,
        OP_READ_BYTE,
        OP_STOP
    } bit_op_t;

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_WR,
        S_ADDR,
        S_DATA_WR,
        S_RESTART,
        S_CTRL_RD,
        S_DATA_RD,
        S_STOP,
        S_DONE
    } seq_state_t;

endpackage

`default_nettype wire

// File: src/i2c_bit_engine.sv
`default_nettype none

module i2c_bit_engine #(
    parameter int SCL_HALF = 2
) (
    input  wire                                CLK,
    input  wire                                RESET,
    input  wire eeprom_ctrl_pkg::bit_op_t      op,
    input  wire                                op_go,
    input  wire [eeprom_bus_pkg::DATA_W-1:0]   tx_byte,
    input  wire                                sda_in,
    output logic                               op_done,
    output logic                               ack_ok,
    output logic [eeprom_bus_pkg::DATA_W-1:0]  rx_byte,
    output logic                               scl,
    output logic                               sda_drive_low
);
    import eeprom_ctrl_pkg::*;
    import eeprom_bus_pkg::*;

    localparam int CNT_W = $clog2(SCL_HALF + 1);
    localparam logic [CNT_W-1:0] CNT_END = CNT_W'(SCL_HALF - 1);
    localparam logic [CNT_W-1:0] CNT_MID = CNT_W'(SCL_HALF / 2 - 1); // sda moves here

    logic              running;
    bit_op_t           cur_op;
    logic [CNT_W-1:0]  cnt;
    logic [4:0]        ph;          // half period index within the op
    logic [4:0]        last_ph;
    logic [DATA_W-1:0] shreg;
    logic              half_mid;
    logic              half_end;
    logic              ack_bit;

    assign half_mid = running && (cnt == CNT_MID);
    assign half_end = running && (cnt == CNT_END);
    assign ack_bit  = (ph[4:1] == 4'd8);
    assign last_ph  = (cur_op == OP_WRITE_BYTE || cur_op == OP_READ_BYTE) ? 5'd17 : 5'd1;
    assign rx_byte  = shreg;

    // msb first byte shifter in both directions
    always_ff @(posedge CLK)
    begin
        if (!running && op_go)
            shreg <= tx_byte;
        else if (half_mid && ph[0] && !ack_bit && cur_op == OP_READ_BYTE)
            shreg <= {shreg[DATA_W-2:0], sda_in};
        else if (half_end && ph[0] && cur_op == OP_WRITE_BYTE)
            shreg <= {shreg[DATA_W-2:0], 1'b0};
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            running       <= 1'b0;
            cur_op        <= OP_STOP;
            cnt           <= '0;
            ph            <= '0;
            op_done       <= 1'b0;
            ack_ok        <= 1'b0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
        end
        else
        begin
            op_done <= 1'b0;
            if (!running)
            begin
                if (op_go)
                begin
                    running <= 1'b1;
                    cur_op  <= op;
                    cnt     <= '0;
                    ph      <= '0;
                end
            end
            else
            begin
                cnt <= half_end ? '0 : cnt + 1'b1;

                if (half_mid)
                begin
                    case (cur_op)
                        OP_START:
                            sda_drive_low <= 1'b1;          // falls under high scl
                        OP_RESTART:
                            sda_drive_low <= ph[0];          // release, then start
                        OP_STOP:
                            sda_drive_low <= !ph[0];         // low, then rise under high scl
                        OP_WRITE_BYTE:
                        begin
                            if (!ph[0])
                                sda_drive_low <= !ack_bit && !shreg[DATA_W-1];
                            else if (ack_bit)
                                ack_ok <= !sda_in;
                        end
                        default:
                        begin
                            if (!ph[0])
                                sda_drive_low <= 1'b0;       // also the nack on bit 9
                        end
                    endcase
                end

                if (half_end)
                begin
                    case (cur_op)
                        OP_START:
                            scl <= 1'b0;
                        OP_STOP:
                            scl <= 1'b1;                     // bus left idle
                        default:
                            scl <= !ph[0];
                    endcase

                    if (ph == last_ph)
                    begin
                        running <= 1'b0;
                        op_done <= 1'b1;
                    end
                    else
                        ph <= ph + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/eeprom_sequencer.sv
`default_nettype none

module eeprom_sequencer (
    input  wire                                CLK,
    input  wire                                RESET,
    input  wire                                wr,
    input  wire                                rd,
    input  wire [eeprom_bus_pkg::ADDR_W-1:0]   addr,
    input  wire [eeprom_bus_pkg::DATA_W-1:0]   wdata,
    input  wire                                op_done,
    input  wire                                ack_ok,
    input  wire [eeprom_bus_pkg::DATA_W-1:0]   rx_byte,
    output eeprom_ctrl_pkg::bit_op_t           op,
    output logic                               op_go,
    output logic [eeprom_bus_pkg::DATA_W-1:0]  tx_byte,
    output logic [eeprom_bus_pkg::DATA_W-1:0]  rdata,
    output logic                               done,
    output logic                               nack_err,
    output logic                               busy
);
    import eeprom_bus_pkg::*;
    import eeprom_ctrl_pkg::*;

    seq_state_t        state;
    seq_state_t        next_state;
    logic              rd_q;        // direction of the pending request
    logic              err;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;

    always_comb
    begin
        case (state)
            S_START:                op = OP_START;
            S_RESTART:              op = OP_RESTART;
            S_CTRL_WR, S_ADDR,
            S_DATA_WR, S_CTRL_RD:   op = OP_WRITE_BYTE;
            S_DATA_RD:              op = OP_READ_BYTE;
            default:                op = OP_STOP;
        endcase
    end

    always_comb
    begin
        case (state)
            S_CTRL_WR: tx_byte = {DEVICE_CODE, addr_q[ADDR_W-1:DATA_W], RW_WRITE};
            S_CTRL_RD: tx_byte = {DEVICE_CODE, addr_q[ADDR_W-1:DATA_W], RW_READ};
            S_ADDR:    tx_byte = addr_q[DATA_W-1:0];
            S_DATA_WR: tx_byte = wdata_q;
            default:   tx_byte = '0;
        endcase
    end

    // refused bytes go straight to the stop
    always_comb
    begin
        case (state)
            S_START:   next_state = S_CTRL_WR;
            S_CTRL_WR: next_state = ack_ok ? S_ADDR : S_STOP;
            S_ADDR:
            begin
                if (!ack_ok)
                    next_state = S_STOP;
                else
                    next_state = rd_q ? S_RESTART : S_DATA_WR;
            end
            S_RESTART: next_state = S_CTRL_RD;
            S_CTRL_RD: next_state = ack_ok ? S_DATA_RD : S_STOP;
            S_STOP:    next_state = S_DONE;
            default:   next_state = S_STOP;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (state == S_IDLE && (wr || rd))
        begin
            addr_q  <= addr;
            wdata_q <= wdata;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= S_IDLE;
            rd_q     <= 1'b0;
            err      <= 1'b0;
            op_go    <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            nack_err <= 1'b0;
            rdata    <= '0;
        end
        else
        begin
            op_go    <= 1'b0;
            done     <= 1'b0;
            nack_err <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (wr || rd)
                    begin
                        rd_q  <= !wr;               // write wins a tie
                        err   <= 1'b0;
                        busy  <= 1'b1;
                        op_go <= 1'b1;
                        state <= S_START;
                    end
                end
                S_DONE:
                begin
                    done     <= 1'b1;
                    nack_err <= err;
                    busy     <= 1'b0;
                    state    <= S_IDLE;
                end
                default:
                begin
                    if (op_done)
                    begin
                        op_go <= (state != S_STOP);
                        state <= next_state;
                        if (op == OP_WRITE_BYTE && !ack_ok)
                            err <= 1'b1;
                        if (state == S_DATA_RD)
                            rdata <= rx_byte;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/eeprom_ctrl_top.sv
`default_nettype none

module eeprom_ctrl_top #(
    parameter int SCL_HALF = 2          // scl = CLK / (2 * SCL_HALF)
) (
    input  wire                                CLK,
    input  wire                                RESET,
    input  wire                                wr,
    input  wire                                rd,
    input  wire [eeprom_bus_pkg::ADDR_W-1:0]   addr,
    input  wire [eeprom_bus_pkg::DATA_W-1:0]   wdata,
    input  wire                                sda_in,
    output wire [eeprom_bus_pkg::DATA_W-1:0]   rdata,
    output wire                                done,
    output wire                                nack_err,
    output wire                                busy,
    output wire                                scl,
    output wire                                sda_drive_low
);
    import eeprom_bus_pkg::*;
    import eeprom_ctrl_pkg::*;

    bit_op_t           op;
    logic              op_go;
    logic              op_done;
    logic              ack_ok;
    logic [DATA_W-1:0] tx_byte;
    logic [DATA_W-1:0] rx_byte;

    eeprom_sequencer seq0 (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .op_done  (op_done),
        .ack_ok   (ack_ok),
        .rx_byte  (rx_byte),
        .op       (op),
        .op_go    (op_go),
        .tx_byte  (tx_byte),
        .rdata    (rdata),
        .done     (done),
        .nack_err (nack_err),
        .busy     (busy)
    );

    i2c_bit_engine #(
        .SCL_HALF (SCL_HALF)
    ) bit0 (
        .CLK           (CLK),
        .RESET         (RESET),
        .op            (op),
        .op_go         (op_go),
        .tx_byte       (tx_byte),
        .sda_in        (sda_in),
        .op_done       (op_done),
        .ack_ok        (ack_ok),
        .rx_byte       (rx_byte),
        .scl           (scl),
        .sda_drive_low (sda_drive_low)
    );

endmodule

`default_nettype wire

// File: bench/eeprom_model.sv
`default_nettype none

module eeprom_model (
    input  wire  scl,
    input  wire  sda,
    input  wire  refuse,            // withhold the ack of the control byte
    output logic sda_low
);
    import eeprom_bus_pkg::*;

    logic [DATA_W-1:0] mem [0:(1 << ADDR_W)-1];
    logic [ADDR_W-1:0] ptr = '0;
    logic [DATA_W-1:0] shreg = '0;
    logic              active = 1'b0;
    logic              read_req = 1'b0;
    logic              sending = 1'b0;
    logic              scl_q = 1'b1;    // bus idles high
    logic              sda_q = 1'b1;
    int                bit_cnt = 0;     // scl rises seen in this byte
    int                byte_idx = 0;

    initial
    begin
        sda_low = 1'b0;
        for (int i = 0; i < (1 << ADDR_W); i++)
            mem[i] = 8'hff;             // erased part
    end

    task bus_start;
        active   = 1'b1;
        bit_cnt  = 0;
        byte_idx = 0;
        read_req = 1'b0;
        sending  = 1'b0;
        sda_low  = 1'b0;
    endtask

    task bus_stop;
        active  = 1'b0;
        sending = 1'b0;
        sda_low = 1'b0;
    endtask

    // ack decision once the eighth bit is in
    task take_byte;
        logic ack;
        ack = 1'b1;
        case (byte_idx)
            0:
            begin
                if (shreg[DATA_W-1:DATA_W-4] != DEVICE_CODE || refuse)
                    ack = 1'b0;
                else if (shreg[0])
                    read_req = 1'b1;
                else
                    ptr[ADDR_W-1:DATA_W] = shreg[3:1];
            end
            1:
                ptr[DATA_W-1:0] = shreg;
            default:
            begin
                mem[ptr] = shreg;
                ptr = ptr + 1'b1;
            end
        endcase
        sda_low = ack;
        if (!ack)
            active = 1'b0;              // ignore the bus until the next start
    endtask

    task scl_rise;
        if (active)
        begin
            if (bit_cnt < 8 && !sending)
                shreg = {shreg[DATA_W-2:0], sda};
            bit_cnt = bit_cnt + 1;
        end
    endtask

    task scl_fall;
        if (active)
        begin
            if (bit_cnt == 8)
            begin
                if (sending)
                    sda_low = 1'b0;     // master answers here
                else
                    take_byte();
            end
            else if (bit_cnt == 9)
            begin
                bit_cnt  = 0;
                byte_idx = byte_idx + 1;
                sda_low  = 1'b0;
                if (sending)
                begin
                    // master ends a read after one byte
                    sending = 1'b0;
                    active  = 1'b0;
                end
                else if (read_req)
                begin
                    sending = 1'b1;
                    shreg   = mem[ptr];
                    ptr     = ptr + 1'b1;
                    sda_low = !shreg[DATA_W-1];
                end
            end
            else if (sending && bit_cnt > 0)
                sda_low = !shreg[DATA_W-1-bit_cnt];
        end
    endtask

    always @(posedge scl or negedge scl or posedge sda or negedge sda)
    begin
        if (scl != scl_q)
        begin
            if (scl)
                scl_rise();
            else
                scl_fall();
        end
        else if (scl && sda != sda_q)
        begin
            if (!sda)
                bus_start();            // also a repeated start that keeps ptr
            else
                bus_stop();
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

`default_nettype wire

// File: bench/tb_eeprom_ctrl.sv
`default_nettype none

module tb_eeprom_ctrl;
    import eeprom_bus_pkg::*;

    localparam int MEM_SIZE  = 1 << ADDR_W;
    localparam int DONE_WAIT = 2000;    // a read takes under 200 CLK cycles

    logic              CLK = 1'b0;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              refuse;
    wire  [DATA_W-1:0] rdata;
    wire               done;
    wire               nack_err;
    wire               busy;
    wire               scl;
    wire               sda_drive_low;
    wire               model_sda_low;
    wire               sda;

    logic [DATA_W-1:0] ref_mem [0:MEM_SIZE-1];
    integer            seed;
    int                done_cnt;

    assign sda = !(sda_drive_low || model_sda_low);     // pull-up on the wire

    eeprom_ctrl_top #(
        .SCL_HALF (2)
    ) dut0 (
        .CLK           (CLK),
        .RESET         (RESET),
        .wr            (wr),
        .rd            (rd),
        .addr          (addr),
        .wdata         (wdata),
        .sda_in        (sda),
        .rdata         (rdata),
        .done          (done),
        .nack_err      (nack_err),
        .busy          (busy),
        .scl           (scl),
        .sda_drive_low (sda_drive_low)
    );

    eeprom_model model0 (
        .scl     (scl),
        .sda     (sda),
        .refuse  (refuse),
        .sda_low (model_sda_low)
    );

    always #2 CLK = ~CLK;

    always @(posedge CLK)
    begin
        if (RESET)
            done_cnt <= 0;
        else if (done)
            done_cnt <= done_cnt + 1;
    end

    task abort_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
    endtask

    function automatic logic [ADDR_W-1:0] pick_addr();
        logic [31:0] r;
        r = $random(seed);
        if (r[31])
            return r[ADDR_W-1:0];
        return r[ADDR_W-1:0] & 11'h70f;     // 128 cells across all blocks
    endfunction

    // strobe then wait for done with optional strobes while busy
    task run_request(input logic is_wr, input logic [ADDR_W-1:0] a,
                     input logic [DATA_W-1:0] d, input logic noise,
                     output logic got_nack, output logic [DATA_W-1:0] got_data);
        int          start_cnt;
        int          n;
        logic [31:0] r;
        start_cnt = done_cnt;
        @(posedge CLK);
        wr    <= is_wr;
        rd    <= !is_wr;
        addr  <= a;
        wdata <= d;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
        n = 0;
        do
        begin
            @(posedge CLK);
            n++;
            wr <= 1'b0;
            rd <= 1'b0;
            if (n == 1)
                check("busy", 32'(busy), 1);
            if (noise && (n == 3 || n == 9))
            begin
                r = $random(seed);
                check("busy", 32'(busy), 1);
                wr    <= r[0];
                rd    <= !r[0];
                addr  <= r[14:4];
                wdata <= r[31:24];
            end
        end
        while (!done && n < DONE_WAIT);
        if (!done)
            abort_run("timeout, no done pulse after a request");
        got_nack = nack_err;
        got_data = rdata;
        check("busy", 32'(busy), 0);
        repeat (3) @(posedge CLK);
        check("done pulses", 32'(done_cnt - start_cnt), 1);
        check("busy", 32'(busy), 0);
        check("scl", 32'(scl), 1);
        check("sda_drive_low", 32'(sda_drive_low), 0);
    endtask

    task access(input logic is_wr, input logic [ADDR_W-1:0] a,
                input logic [DATA_W-1:0] d, input logic noise);
        logic              got_nack;
        logic [DATA_W-1:0] got_data;
        logic [DATA_W-1:0] prev_data;
        prev_data = rdata;
        run_request(is_wr, a, d, noise, got_nack, got_data);
        check("nack_err", 32'(got_nack), 32'(refuse));
        if (is_wr && !refuse)
            ref_mem[a] = d;
        else if (!is_wr && refuse)
            check("rdata", 32'(got_data), 32'(prev_data));
        else if (!is_wr)
            check("rdata", 32'(got_data), 32'(ref_mem[a]));
    endtask

    initial
    begin
        logic [31:0]       r;
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] d;
        seed   = 32'h32d9;
        RESET  = 1'b1;
        wr     = 1'b0;
        rd     = 1'b0;
        addr   = '0;
        wdata  = '0;
        refuse = 1'b0;
        for (int i = 0; i < MEM_SIZE; i++)
            ref_mem[i] = 8'hff;
        repeat (4) @(posedge CLK);
        RESET <= 1'b0;
        @(posedge CLK);
        check("busy", 32'(busy), 0);
        check("done", 32'(done), 0);
        check("nack_err", 32'(nack_err), 0);
        check("scl", 32'(scl), 1);
        check("sda_drive_low", 32'(sda_drive_low), 0);
        check("rdata", 32'(rdata), 0);

        for (int i = 0; i < 200; i++)
        begin
            r = $random(seed);
            access(r[0], pick_addr(), r[15:8], 1'b0);
        end

        // write then read back anywhere in the array
        for (int i = 0; i < 20; i++)
        begin
            r = $random(seed);
            a = r[ADDR_W-1:0];
            d = r[31:24];
            access(1'b1, a, d, 1'b0);
            access(1'b0, a, '0, 1'b0);
            check("rdata", 32'(rdata), 32'(d));
        end

        @(posedge CLK);
        refuse <= 1'b1;
        for (int i = 0; i < 10; i++)
        begin
            r = $random(seed);
            access(r[0], pick_addr(), r[15:8], 1'b0);
        end
        @(posedge CLK);
        refuse <= 1'b0;

        // extra strobes land while busy
        for (int i = 0; i < 20; i++)
        begin
            r = $random(seed);
            access(r[0], pick_addr(), r[15:8], 1'b1);
        end

        for (int i = 0; i < MEM_SIZE; i++)
            check($sformatf("model0.mem[%0h]", i), 32'(model0.mem[i]), 32'(ref_mem[i]));

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
src/eeprom_bus_pkg.sv
src/eeprom_ctrl_pkg.sv
src/i2c_bit_engine.sv
src/eeprom_sequencer.sv
src/eeprom_ctrl_top.sv
bench/eeprom_model.sv
bench/tb_eeprom_ctrl.sv

// File: Makefile
TOP = tb_eeprom_ctrl

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --top-module eeprom_ctrl_top \
		src/eeprom_bus_pkg.sv src/eeprom_ctrl_pkg.sv src/i2c_bit_engine.sv \
		src/eeprom_sequencer.sv src/eeprom_ctrl_top.sv

sim:
	verilator --binary --top-module $(TOP) -f all.f -o V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
